/* design/rob_data_pkg.sv */
package rob_data_pkg;

    // architectural register file geometry
    localparam int reg_idx_w = 5;
    localparam int word_w    = 32;

    // index into the architectural register file
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // one register data value, as carried on the result bus
    typedef logic [word_w-1:0] word_t;

    // hard-wired zero register, never written at commit
    localparam reg_idx_t zero_reg = reg_idx_t'(0);

endpackage

/* design/rob_ctrl_pkg.sv */
package rob_ctrl_pkg;

    // commit side state machine
    // commit_run   normal in-order retirement
    // commit_flush one recovery cycle after a mispredict commits
    typedef enum logic {
        commit_run   = 1'b0,
        commit_flush = 1'b1
    } commit_state_t;

endpackage

/* design/rob_dispatch.sv */
`timescale 1ns/100ps

module rob_dispatch #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth),
    localparam int cnt_w = tag_w + 1
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        dispatch_valid,
    input  logic                        commit_fire,
    input  logic                        squash,
    input  rob_ctrl_pkg::commit_state_t commit_state,
    output logic                        dispatch_ready,
    output logic [tag_w-1:0]            dispatch_tag,
    output logic                        alloc_en
);

    logic [tag_w-1:0] tail;
    logic [cnt_w-1:0] count;    // entries in flight, 0 .. rob_depth
    logic             full;

    assign full = (count == cnt_w'(rob_depth));

    // no allocation while the buffer recovers from a squash
    assign dispatch_ready = !full && (commit_state == rob_ctrl_pkg::commit_run);
    assign dispatch_tag   = tail;
    assign alloc_en       = dispatch_valid && dispatch_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            tail  <= '0;    // younger entries are gone, restart at slot 0
            count <= '0;
        end else begin
            if (alloc_en)
                tail <= tail + 1'b1;    // wraps, depth is a power of two
            if (alloc_en && !commit_fire)
                count <= count + 1'b1;
            else if (commit_fire && !alloc_en)
                count <= count - 1'b1;
        end
    end

    // occupancy has to agree with the commits seen from the retire side
    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= cnt_w'(rob_depth))
        else $error("rob_dispatch: occupancy above depth");

    // a commit can only retire an entry that was counted in
    a_commit_nonempty: assert property (@(posedge clock) disable iff (reset)
        commit_fire |-> count != '0)
        else $error("rob_dispatch: commit with an empty buffer");

endmodule

/* design/rob_entry_array.sv */
`timescale 1ns/100ps

module rob_entry_array #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   alloc_en,
    input  logic [tag_w-1:0]       dispatch_tag,
    input  rob_data_pkg::reg_idx_t dispatch_dest,
    input  logic                   cdb_valid,
    input  logic [tag_w-1:0]       cdb_tag,
    input  rob_data_pkg::word_t    cdb_value,
    input  logic                   cdb_mispredict,
    input  logic [tag_w-1:0]       head_tag,
    input  logic [tag_w-1:0]       src_tag_a,
    input  logic [tag_w-1:0]       src_tag_b,
    input  logic                   commit_fire,
    input  logic                   squash,
    output logic                   head_done,
    output rob_data_pkg::reg_idx_t head_dest,
    output rob_data_pkg::word_t    head_value,
    output logic                   head_mispredict,
    output rob_data_pkg::word_t    src_value_a,
    output logic                   src_done_a,
    output rob_data_pkg::word_t    src_value_b,
    output logic                   src_done_b
);

    // per-entry control bits
    logic [rob_depth-1:0] busy;
    logic [rob_depth-1:0] done;
    logic [rob_depth-1:0] mispredict;

    // per-entry payload
    rob_data_pkg::reg_idx_t dest  [rob_depth];
    rob_data_pkg::word_t    value [rob_depth];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy       <= '0;
            done       <= '0;
            mispredict <= '0;
        end else begin
            for (int i = 0; i < rob_depth; i++) begin
                if (alloc_en && dispatch_tag == tag_w'(i)) begin
                    busy[i]       <= 1'b1;
                    done[i]       <= 1'b0;
                    mispredict[i] <= 1'b0;
                end
                if (cdb_valid && cdb_tag == tag_w'(i)) begin
                    done[i]       <= 1'b1;
                    mispredict[i] <= cdb_mispredict;
                end
                // retired entry frees its slot
                if (commit_fire && head_tag == tag_w'(i))
                    busy[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rob_depth; i++) begin
            if (alloc_en && dispatch_tag == tag_w'(i)) begin
                dest[i]  <= dispatch_dest;
                value[i] <= '0;
            end else if (cdb_valid && cdb_tag == tag_w'(i)) begin
                value[i] <= cdb_value;
            end
        end
    end

    // head port for the retire side
    assign head_done       = busy[head_tag] && done[head_tag];
    assign head_dest       = dest[head_tag];
    assign head_value      = value[head_tag];
    assign head_mispredict = mispredict[head_tag];

    // operand forwarding, stored state only, no cdb bypass
    assign src_value_a = value[src_tag_a];
    assign src_done_a  = busy[src_tag_a] && done[src_tag_a];
    assign src_value_b = value[src_tag_b];
    assign src_done_b  = busy[src_tag_b] && done[src_tag_b];

    // the result bus may only complete an in-flight, unfinished entry
    a_cdb_target: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> busy[cdb_tag] && !done[cdb_tag])
        else $error("rob_entry_array: completion to tag %0d not pending", cdb_tag);

endmodule

/* design/rob_retire.sv */
`timescale 1ns/100ps

module rob_retire #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        head_done,
    input  rob_data_pkg::reg_idx_t      head_dest,
    input  rob_data_pkg::word_t         head_value,
    input  logic                        head_mispredict,
    input  logic                        commit_ready,
    output logic [tag_w-1:0]            head_tag,
    output logic                        commit_valid,
    output rob_data_pkg::reg_idx_t      commit_dest,
    output rob_data_pkg::word_t         commit_value,
    output logic                        commit_write_en,
    output logic                        commit_fire,
    output logic                        squash,
    output rob_ctrl_pkg::commit_state_t commit_state
);

    // head entry goes out as soon as it is done
    assign commit_valid = head_done && (commit_state == rob_ctrl_pkg::commit_run);
    assign commit_fire  = commit_valid && commit_ready;
    assign commit_dest  = head_dest;
    assign commit_value = head_value;

    // writes to the zero register are dropped
    assign commit_write_en = commit_valid && (head_dest != rob_data_pkg::zero_reg);

    // mispredicted branch squashes everything behind it
    assign squash = commit_fire && head_mispredict;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_state <= rob_ctrl_pkg::commit_run;
            head_tag     <= '0;
        end else begin
            case (commit_state)
                rob_ctrl_pkg::commit_run: begin
                    if (squash) begin
                        commit_state <= rob_ctrl_pkg::commit_flush;
                        head_tag     <= '0;
                    end else if (commit_fire) begin
                        head_tag <= head_tag + 1'b1;
                    end
                end
                rob_ctrl_pkg::commit_flush: begin
                    commit_state <= rob_ctrl_pkg::commit_run;    // one cycle only
                end
                default: begin
                    commit_state <= rob_ctrl_pkg::commit_run;
                end
            endcase
        end
    end

    // the squash edge clears every entry, so nothing is left to retire
    a_flush_empty: assert property (@(posedge clock) disable iff (reset)
        squash |=> !head_done)
        else $error("rob_retire: entry still done after squash");

    // a stalled commit keeps its payload until the register file takes it
    a_commit_hold: assert property (@(posedge clock) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_dest)
                                          && $stable(commit_value))
        else $error("rob_retire: stalled commit changed");

endmodule

/* design/rob_top.sv */
`timescale 1ns/100ps

module rob_top #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  rob_data_pkg::reg_idx_t dispatch_dest,
    input  logic                   cdb_valid,
    input  logic [tag_w-1:0]       cdb_tag,
    input  rob_data_pkg::word_t    cdb_value,
    input  logic                   cdb_mispredict,
    input  logic [tag_w-1:0]       src_tag_a,
    input  logic [tag_w-1:0]       src_tag_b,
    input  logic                   commit_ready,
    output logic                   dispatch_ready,
    output logic [tag_w-1:0]       dispatch_tag,
    output rob_data_pkg::word_t    src_value_a,
    output logic                   src_done_a,
    output rob_data_pkg::word_t    src_value_b,
    output logic                   src_done_b,
    output logic                   commit_valid,
    output rob_data_pkg::reg_idx_t commit_dest,
    output rob_data_pkg::word_t    commit_value,
    output logic                   commit_write_en,
    output logic                   squash
);

    logic                        alloc_en;
    logic [tag_w-1:0]            head_tag;
    logic                        head_done;
    rob_data_pkg::reg_idx_t      head_dest;
    rob_data_pkg::word_t         head_value;
    logic                        head_mispredict;
    logic                        commit_fire;
    rob_ctrl_pkg::commit_state_t commit_state;

    rob_dispatch #(.rob_depth(rob_depth)) u_dispatch (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .commit_fire(commit_fire),
        .squash(squash), .commit_state(commit_state),
        .dispatch_ready(dispatch_ready), .dispatch_tag(dispatch_tag),
        .alloc_en(alloc_en)
    );

    // dispatch_tag doubles as the allocation tag
    rob_entry_array #(.rob_depth(rob_depth)) u_entry_array (
        .clock(clock), .reset(reset),
        .alloc_en(alloc_en), .dispatch_tag(dispatch_tag), .dispatch_dest(dispatch_dest),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .cdb_mispredict(cdb_mispredict), .head_tag(head_tag),
        .src_tag_a(src_tag_a), .src_tag_b(src_tag_b),
        .commit_fire(commit_fire), .squash(squash),
        .head_done(head_done), .head_dest(head_dest), .head_value(head_value),
        .head_mispredict(head_mispredict),
        .src_value_a(src_value_a), .src_done_a(src_done_a),
        .src_value_b(src_value_b), .src_done_b(src_done_b)
    );

    rob_retire #(.rob_depth(rob_depth)) u_retire (
        .clock(clock), .reset(reset),
        .head_done(head_done), .head_dest(head_dest), .head_value(head_value),
        .head_mispredict(head_mispredict), .commit_ready(commit_ready),
        .head_tag(head_tag), .commit_valid(commit_valid), .commit_dest(commit_dest),
        .commit_value(commit_value), .commit_write_en(commit_write_en),
        .commit_fire(commit_fire), .squash(squash), .commit_state(commit_state)
    );

endmodule

/* verification/tb_rob_top.sv */
`timescale 1ns/100ps

module tb_rob_top;

    localparam int rob_depth     = 8;
    localparam int tag_w         = $clog2(rob_depth);
    localparam int timeout_limit = 50;    // cycles per wait
    localparam int pattern_words = 512;   // four words per operation
    localparam string pattern_file = "verification/rob_patterns.txt";

    logic                   clock;
    logic                   reset;
    logic                   dispatch_valid;
    rob_data_pkg::reg_idx_t dispatch_dest;
    logic                   cdb_valid;
    logic [tag_w-1:0]       cdb_tag;
    rob_data_pkg::word_t    cdb_value;
    logic                   cdb_mispredict;
    logic [tag_w-1:0]       src_tag_a;
    logic [tag_w-1:0]       src_tag_b;
    logic                   commit_ready;
    logic                   dispatch_ready;
    logic [tag_w-1:0]       dispatch_tag;
    rob_data_pkg::word_t    src_value_a;
    logic                   src_done_a;
    rob_data_pkg::word_t    src_value_b;
    logic                   src_done_b;
    logic                   commit_valid;
    rob_data_pkg::reg_idx_t commit_dest;
    rob_data_pkg::word_t    commit_value;
    logic                   commit_write_en;
    logic                   squash;

    logic [31:0] patterns [pattern_words];
    int          errors;
    int          checks;
    int          tests;
    logic        timed_out;

    rob_top #(.rob_depth(rob_depth)) dut (.*);

    always #2 clock = ~clock;

    // every drive lands just after the rising edge
    task automatic tick();
        @(posedge clock);
        #0.5;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic wait_commit_valid();
        int n;
        n = 0;
        #1;
        while (!commit_valid && n < timeout_limit) begin
            tick();
            #1;
            n++;
        end
        if (!commit_valid) begin
            $display("timeout at %0t: no commit became valid", $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic dispatch_one(input logic [31:0] dest, input logic [31:0] exp_tag);
        int n;
        n = 0;
        tick();
        dispatch_valid = 1'b1;
        dispatch_dest  = rob_data_pkg::reg_idx_t'(dest);
        #1;
        while (!dispatch_ready && n < timeout_limit) begin
            tick();
            #1;
            n++;
        end
        if (!dispatch_ready) begin
            $display("timeout at %0t: dispatch was never accepted", $time);
            timed_out = 1'b1;
        end else begin
            check_value("dispatch_tag", 32'(dispatch_tag), exp_tag);
        end
        tick();    // handshake taken at this edge
        dispatch_valid = 1'b0;
    endtask

    task automatic complete_one(input logic [31:0] tag, input logic [31:0] value,
                                input logic [31:0] misp);
        tick();
        cdb_valid      = 1'b1;
        cdb_tag        = tag_w'(tag);
        cdb_value      = value;
        cdb_mispredict = misp[0];
        tick();
        cdb_valid      = 1'b0;
        cdb_mispredict = 1'b0;
    endtask

    // each port in turn, the other one parked on a different entry
    task automatic read_source(input logic [31:0] tag, input logic [31:0] value,
                               input logic [31:0] done);
        tick();
        src_tag_a = tag_w'(tag);
        src_tag_b = tag_w'(~tag);
        #1;
        check_value("src_value_a", src_value_a, value);
        check_value("src_done_a", 32'(src_done_a), done);
        tick();
        src_tag_a = tag_w'(~tag);
        src_tag_b = tag_w'(tag);
        #1;
        check_value("src_value_b", src_value_b, value);
        check_value("src_done_b", 32'(src_done_b), done);
    endtask

    task automatic commit_one(input logic [31:0] dest, input logic [31:0] value,
                              input logic [31:0] we, input logic [31:0] sq);
        tick();
        wait_commit_valid();
        if (!timed_out) begin
            tick();
            commit_ready = 1'b1;
            #1;
            check_value("commit_dest", 32'(commit_dest), dest);
            check_value("commit_value", commit_value, value);
            check_value("commit_write_en", 32'(commit_write_en), we);
            check_value("squash", 32'(squash), sq);
            tick();
            commit_ready = 1'b0;
            if (sq[0]) begin
                // one quiet flush cycle, then dispatch reopens
                #1;
                check_value("dispatch_ready in flush", 32'(dispatch_ready), 0);
                check_value("commit_valid in flush", 32'(commit_valid), 0);
                tick();
                #1;
                check_value("dispatch_ready after flush", 32'(dispatch_ready), 1);
            end
        end
    endtask

    task automatic hold_commit(input logic [31:0] cycles);
        rob_data_pkg::reg_idx_t held_dest;
        rob_data_pkg::word_t    held_value;
        int                     i;
        tick();
        wait_commit_valid();
        held_dest  = commit_dest;
        held_value = commit_value;
        for (i = 0; i < cycles && !timed_out; i++) begin
            tick();
            #1;
            check_value("held commit_valid", 32'(commit_valid), 1);
            check_value("held commit_dest", 32'(commit_dest), 32'(held_dest));
            check_value("held commit_value", commit_value, held_value);
        end
    endtask

    task automatic check_dispatch_ready(input logic [31:0] expected);
        tick();
        #1;
        check_value("dispatch_ready", 32'(dispatch_ready), expected);
    endtask

    initial begin
        logic [$clog2(pattern_words)-1:0] pc;
        logic [31:0]                      op;
        int                               test_start_errors;
        void'($urandom(32'he78fced3));
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_dest  = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        cdb_mispredict = 1'b0;
        src_tag_a      = '0;
        src_tag_b      = '0;
        commit_ready   = 1'b0;    // low unless a commit is expected
        errors         = 0;
        checks         = 0;
        tests          = 0;
        timed_out      = 1'b0;
        $readmemh(pattern_file, patterns);
        repeat (2) @(posedge clock);
        #0.5;
        reset = 1'b0;
        #1;
        check_value("dispatch_ready after reset", 32'(dispatch_ready), 1);
        check_value("commit_valid after reset", 32'(commit_valid), 0);
        check_value("squash after reset", 32'(squash), 0);
        pc = '0;
        test_start_errors = 0;
        op = patterns[pc];
        while (op != 0 && !timed_out) begin
            case (op)
                1: dispatch_one(patterns[pc + 1], patterns[pc + 2]);
                2: complete_one(patterns[pc + 1], patterns[pc + 2], patterns[pc + 3]);
                3: read_source(patterns[pc + 1], patterns[pc + 2], patterns[pc + 3]);
                4: commit_one(patterns[pc + 1], patterns[pc + 2], patterns[pc + 3], 0);
                5: hold_commit(patterns[pc + 1]);
                6: commit_one(patterns[pc + 1], patterns[pc + 2], patterns[pc + 3], 1);
                7: check_dispatch_ready(patterns[pc + 3]);
                8: begin
                    tests++;
                    $display("test %0d done, %0d errors", patterns[pc + 1],
                             errors - test_start_errors);
                    test_start_errors = errors;
                end
                default: begin
                    $display("unknown opcode %0h in the pattern file", op);
                    errors++;
                end
            endcase
            repeat ($urandom_range(2, 0)) tick();    // idle gap
            pc = pc + 4;
            op = patterns[pc];
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verification/rob_patterns.txt */
// op arg value flag, all hex, one operation per line
// 1 dispatch dest/tag  2 complete tag/value/mispredict  3 read tag/value/done
// 4 commit dest/value/write_en  5 hold ready low arg cycles  6 commit with squash
// 7 dispatch_ready is flag  8 end of test arg  0 end of file
1 01 00000000 0
1 02 00000001 0
1 00 00000002 0
1 04 00000003 0
1 05 00000004 0
1 06 00000005 0
1 07 00000006 0
1 08 00000007 0
7 00 00000000 0
3 07 00000000 0
2 07 c0de0007 0
2 06 c0de0006 0
2 05 c0de0005 0
2 04 c0de0004 0
2 03 c0de0003 0
2 02 c0de0002 0
2 01 c0de0001 0
2 00 c0de0000 0
3 07 c0de0007 1
8 01 00000000 0
4 01 c0de0000 1
7 00 00000000 1
1 09 00000000 0
4 02 c0de0001 1
4 00 c0de0002 0
4 04 c0de0003 1
4 05 c0de0004 1
4 06 c0de0005 1
4 07 c0de0006 1
4 08 c0de0007 1
3 00 00000000 0
2 00 0000beef 0
4 09 0000beef 1
8 02 00000000 0
1 11 00000001 0
1 12 00000002 0
1 13 00000003 0
2 03 33333333 0
2 02 22222222 0
2 01 11111111 1
6 11 11111111 1
1 14 00000000 0
2 00 44444444 0
4 14 44444444 1
8 03 00000000 0
1 15 00000001 0
1 16 00000002 0
2 02 66666666 0
2 01 55555555 0
5 03 00000000 0
4 15 55555555 1
5 02 00000000 0
4 16 66666666 1
8 04 00000000 0
0 00 00000000 0

/* vlog.f */
design/rob_data_pkg.sv
design/rob_ctrl_pkg.sv
design/rob_dispatch.sv
design/rob_entry_array.sv
design/rob_retire.sv
design/rob_top.sv
verification/tb_rob_top.sv

/* Makefile */
TOP = tb_rob_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
